/* Bender.yml */
package:
  name: controlunit

sources:
  - files:
      - src/isaPkg.sv
      - src/controlPkg.sv
      - src/instructionDecoder.sv
      - src/stepSequencer.sv
      - src/controlSignalGenerator.sv
      - src/controlUnit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbControlUnit.sv

/* src/controlPkg.sv */
package controlPkg;

	// Sequencer phases
	typedef enum logic [2:0] {
		phaseClear,
		phaseFetch0,
		phaseFetch1,
		phaseFetch2,
		phaseExecute,
		phaseHalted
	} phaseT;

	// ------------------------------------------------------------------
	// Execute step counter
	// ------------------------------------------------------------------
	localparam int stepWidth = 3;

	// Step index, counting from 0
	typedef logic [stepWidth-1:0] stepT;

	// Load is the longest instruction
	localparam stepT maxExecSteps = 3'd5;

endpackage

/* src/controlSignalGenerator.sv */
module controlSignalGenerator (
	input  controlPkg::phaseT phase,
	input  controlPkg::stepT  step,
	input  isaPkg::opcodeT    opcode,
	input  logic              conff,
	output logic              pcOut,
	output logic              mdrOut,
	output logic              zOut,
	output logic              rIn,
	output logic              rOut,
	output logic              gra,
	output logic              grb,
	output logic              grc,
	output logic              baOut,
	output logic              cSignOut,
	output logic              outPortIn,
	output logic              inPortOut,
	output logic              mdrIn,
	output logic              marIn,
	output logic              yIn,
	output logic              irIn,
	output logic              pcIn,
	output logic              conIn,
	output logic              incPc,
	output logic              memRead,
	output logic              memWrite,
	output logic              zIn,
	output isaPkg::aluOpT     aluOp
);

	isaPkg::aluOpT aluSel;
	logic          isImmediate;

	// ALU function implied by the opcode
	always_comb begin
		case (opcode)
			isaPkg::opAdd, isaPkg::opAddi: aluSel = isaPkg::aluAdd;
			isaPkg::opSub:                 aluSel = isaPkg::aluSub;
			isaPkg::opAnd, isaPkg::opAndi: aluSel = isaPkg::aluAnd;
			isaPkg::opOr, isaPkg::opOri:   aluSel = isaPkg::aluOr;
			isaPkg::opShr:                 aluSel = isaPkg::aluShr;
			isaPkg::opShra:                aluSel = isaPkg::aluShra;
			isaPkg::opShl:                 aluSel = isaPkg::aluShl;
			isaPkg::opRor:                 aluSel = isaPkg::aluRor;
			isaPkg::opRol:                 aluSel = isaPkg::aluRol;
			isaPkg::opNeg:                 aluSel = isaPkg::aluNeg;
			isaPkg::opNot:                 aluSel = isaPkg::aluNot;
			default:                       aluSel = isaPkg::aluNone;
		endcase
	end

	assign isImmediate = (opcode == isaPkg::opAddi) || (opcode == isaPkg::opAndi) ||
		(opcode == isaPkg::opOri);

	always_comb begin
		pcOut     = 1'b0;
		mdrOut    = 1'b0;
		zOut      = 1'b0;
		rIn       = 1'b0;
		rOut      = 1'b0;
		gra       = 1'b0;
		grb       = 1'b0;
		grc       = 1'b0;
		baOut     = 1'b0;
		cSignOut  = 1'b0;
		outPortIn = 1'b0;
		inPortOut = 1'b0;
		mdrIn     = 1'b0;
		marIn     = 1'b0;
		yIn       = 1'b0;
		irIn      = 1'b0;
		pcIn      = 1'b0;
		conIn     = 1'b0;
		incPc     = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		zIn       = 1'b0;
		aluOp     = isaPkg::aluNone;

		case (phase)
			// ----------------------------------------------------------
			// Fetch
			// ----------------------------------------------------------
			controlPkg::phaseFetch0: begin
				pcOut = 1'b1;
				marIn = 1'b1;
				incPc = 1'b1;
				zIn   = 1'b1;
			end
			controlPkg::phaseFetch1: begin
				zOut    = 1'b1;
				pcIn    = 1'b1;
				memRead = 1'b1;
				mdrIn   = 1'b1;
			end
			controlPkg::phaseFetch2: begin
				mdrOut = 1'b1;
				irIn   = 1'b1;
			end

			// ----------------------------------------------------------
			// Execute
			// ----------------------------------------------------------
			controlPkg::phaseExecute: begin
				case (opcode)
					// Address is base register plus sign-extended constant
					isaPkg::opLd, isaPkg::opLdi, isaPkg::opSt: begin
						case (step)
							3'd0: begin
								grb   = 1'b1;
								baOut = 1'b1;
								yIn   = 1'b1;
							end
							3'd1: begin
								cSignOut = 1'b1;
								aluOp    = isaPkg::aluAdd;
								zIn      = 1'b1;
							end
							3'd2: begin
								zOut = 1'b1;
								if (opcode == isaPkg::opLdi) begin
									gra = 1'b1;
									rIn = 1'b1;
								end else begin
									marIn = 1'b1;
								end
							end
							3'd3: begin
								if (opcode == isaPkg::opLd) begin
									memRead = 1'b1;
									mdrIn   = 1'b1;
								end else if (opcode == isaPkg::opSt) begin
									gra      = 1'b1;
									rOut     = 1'b1;
									memWrite = 1'b1;
								end
							end
							3'd4: begin
								mdrOut = 1'b1;
								gra    = 1'b1;
								rIn    = 1'b1;
							end
							default: ;
						endcase
					end

					isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
					isaPkg::opShr, isaPkg::opShra, isaPkg::opShl,
					isaPkg::opRor, isaPkg::opRol,
					isaPkg::opAddi, isaPkg::opAndi, isaPkg::opOri: begin
						case (step)
							3'd0: begin
								grb  = 1'b1;
								rOut = 1'b1;
								yIn  = 1'b1;
							end
							3'd1: begin
								// Second operand from rC or the constant field
								if (isImmediate) begin
									cSignOut = 1'b1;
								end else begin
									grc  = 1'b1;
									rOut = 1'b1;
								end
								aluOp = aluSel;
								zIn   = 1'b1;
							end
							3'd2: begin
								zOut = 1'b1;
								gra  = 1'b1;
								rIn  = 1'b1;
							end
							default: ;
						endcase
					end

					// Unary ops skip the Y load
					isaPkg::opNeg, isaPkg::opNot: begin
						if (step == 3'd0) begin
							grb   = 1'b1;
							rOut  = 1'b1;
							aluOp = aluSel;
							zIn   = 1'b1;
						end else if (step == 3'd1) begin
							zOut = 1'b1;
							gra  = 1'b1;
							rIn  = 1'b1;
						end
					end

					isaPkg::opBr: begin
						case (step)
							3'd0: begin
								gra   = 1'b1;
								rOut  = 1'b1;
								conIn = 1'b1;
							end
							3'd1: begin
								pcOut = 1'b1;
								yIn   = 1'b1;
							end
							3'd2: begin
								cSignOut = 1'b1;
								aluOp    = isaPkg::aluAdd;
								zIn      = 1'b1;
							end
							3'd3: begin
								// Target only taken when the condition held
								zOut = 1'b1;
								pcIn = conff;
							end
							default: ;
						endcase
					end

					isaPkg::opJr: begin
						gra  = 1'b1;
						rOut = 1'b1;
						pcIn = 1'b1;
					end

					// Step 0 waits for the input port data
					isaPkg::opIn: begin
						if (step == 3'd1) begin
							inPortOut = 1'b1;
							gra       = 1'b1;
							rIn       = 1'b1;
						end
					end

					isaPkg::opOut: begin
						gra       = 1'b1;
						rOut      = 1'b1;
						outPortIn = 1'b1;
					end

					default: ;
				endcase
			end

			default: ;
		endcase
	end

	// Register select and the shared bus each have a single owner per cycle
	always_comb begin
		assert final ($onehot0({gra, grb, grc}))
			else $error("more than one register select active");
		assert final ($onehot0({pcOut, mdrOut, zOut, rOut, baOut, cSignOut, inPortOut}))
			else $error("bus driven by more than one source");
	end

endmodule

/* src/controlUnit.sv */
module controlUnit #(
	parameter int wordWidth = 32
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [wordWidth-1:0] irReg,
	input  logic                 conff,
	output logic                 pcOut,
	output logic                 mdrOut,
	output logic                 zOut,
	output logic                 rIn,
	output logic                 rOut,
	output logic                 gra,
	output logic                 grb,
	output logic                 grc,
	output logic                 baOut,
	output logic                 cSignOut,
	output logic                 outPortIn,
	output logic                 inPortOut,
	output logic                 mdrIn,
	output logic                 marIn,
	output logic                 yIn,
	output logic                 irIn,
	output logic                 pcIn,
	output logic                 conIn,
	output logic                 incPc,
	output logic                 memRead,
	output logic                 memWrite,
	output logic                 zIn,
	output isaPkg::aluOpT        aluOp,
	output logic                 run,
	output logic                 clear
);

	isaPkg::opcodeT    opcode;
	controlPkg::stepT  execSteps;
	controlPkg::phaseT phase;
	controlPkg::stepT  step;

	// ------------------------------------------------------------------
	// Decode, sequence, strobe table
	// ------------------------------------------------------------------
	instructionDecoder #(
		.wordWidth(wordWidth)
	) i_instructionDecoder (
		.irReg    (irReg),
		.opcode   (opcode),
		.execSteps(execSteps)
	);

	stepSequencer i_stepSequencer (
		.clock    (clock),
		.reset    (reset),
		.opcode   (opcode),
		.execSteps(execSteps),
		.phase    (phase),
		.step     (step),
		.run      (run),
		.clear    (clear)
	);

	controlSignalGenerator i_controlSignalGenerator (
		.phase    (phase),
		.step     (step),
		.opcode   (opcode),
		.conff    (conff),
		.pcOut    (pcOut),
		.mdrOut   (mdrOut),
		.zOut     (zOut),
		.rIn      (rIn),
		.rOut     (rOut),
		.gra      (gra),
		.grb      (grb),
		.grc      (grc),
		.baOut    (baOut),
		.cSignOut (cSignOut),
		.outPortIn(outPortIn),
		.inPortOut(inPortOut),
		.mdrIn    (mdrIn),
		.marIn    (marIn),
		.yIn      (yIn),
		.irIn     (irIn),
		.pcIn     (pcIn),
		.conIn    (conIn),
		.incPc    (incPc),
		.memRead  (memRead),
		.memWrite (memWrite),
		.zIn      (zIn),
		.aluOp    (aluOp)
	);

endmodule

/* src/instructionDecoder.sv */
module instructionDecoder #(
	parameter int wordWidth = 32
) (
	input  logic [wordWidth-1:0] irReg,
	output isaPkg::opcodeT       opcode,
	output controlPkg::stepT     execSteps
);

	logic [isaPkg::opcodeWidth-1:0] opcodeField;

	// Opcode is always the top bits of IR
	assign opcodeField = irReg[wordWidth-1 -: isaPkg::opcodeWidth];

	// Unknown codes fall back to nop
	always_comb begin
		case (opcodeField)
			isaPkg::opLd, isaPkg::opLdi, isaPkg::opSt,
			isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
			isaPkg::opShr, isaPkg::opShra, isaPkg::opShl,
			isaPkg::opRor, isaPkg::opRol,
			isaPkg::opAddi, isaPkg::opAndi, isaPkg::opOri,
			isaPkg::opNeg, isaPkg::opNot,
			isaPkg::opBr, isaPkg::opJr,
			isaPkg::opIn, isaPkg::opOut,
			isaPkg::opNop, isaPkg::opHalt:
				opcode = isaPkg::opcodeT'(opcodeField);
			default:
				opcode = isaPkg::opNop;
		endcase
	end

	// ------------------------------------------------------------------
	// Execute step count per opcode
	// ------------------------------------------------------------------
	always_comb begin
		case (opcode)
			isaPkg::opLd:                  execSteps = 3'd5;
			isaPkg::opSt, isaPkg::opBr:    execSteps = 3'd4;
			isaPkg::opNeg, isaPkg::opNot:  execSteps = 3'd2;
			isaPkg::opIn:                  execSteps = 3'd2;
			isaPkg::opJr, isaPkg::opOut:   execSteps = 3'd1;
			isaPkg::opNop:                 execSteps = 3'd1;
			// Halt never enters execute
			isaPkg::opHalt:                execSteps = 3'd0;
			// ldi plus all register and immediate ALU ops
			default:                       execSteps = 3'd3;
		endcase
	end

	// Sequencer counter and generator table only cover this range
	always_comb begin
		assert final (execSteps <= controlPkg::maxExecSteps)
			else $error("execSteps %0d above maximum", execSteps);
	end

endmodule

/* src/isaPkg.sv */
package isaPkg;

	// Opcode field sits in the top bits of the instruction word
	localparam int opcodeWidth = 5;

	// ------------------------------------------------------------------
	// Opcodes
	// ------------------------------------------------------------------
	typedef enum logic [opcodeWidth-1:0] {
		opLd   = 5'b00000,
		opLdi  = 5'b00001,
		opSt   = 5'b00010,
		opAdd  = 5'b00011,
		opSub  = 5'b00100,
		opShr  = 5'b00101,
		opShra = 5'b00110,
		opShl  = 5'b00111,
		opRor  = 5'b01000,
		opRol  = 5'b01001,
		opAnd  = 5'b01010,
		opOr   = 5'b01011,
		opAddi = 5'b01100,
		opAndi = 5'b01101,
		opOri  = 5'b01110,
		opNeg  = 5'b10001,
		opNot  = 5'b10010,
		opBr   = 5'b10011,
		opJr   = 5'b10100,
		opIn   = 5'b10110,
		opOut  = 5'b10111,
		opNop  = 5'b11010,
		opHalt = 5'b11011
	} opcodeT;

	// ------------------------------------------------------------------
	// ALU operations
	// ------------------------------------------------------------------
	typedef enum logic [3:0] {
		aluNone,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShr,
		aluShra,
		aluShl,
		aluRor,
		aluRol,
		aluNeg,
		aluNot
	} aluOpT;

endpackage

/* src/stepSequencer.sv */
module stepSequencer (
	input  logic              clock,
	input  logic              reset,
	input  isaPkg::opcodeT    opcode,
	input  controlPkg::stepT  execSteps,
	output controlPkg::phaseT phase,
	output controlPkg::stepT  step,
	output logic              run,
	output logic              clear
);

	controlPkg::phaseT phaseNext;
	controlPkg::stepT  stepNext;
	logic              lastStep;

	assign lastStep = (step == execSteps - 3'd1);

	// ------------------------------------------------------------------
	// Next phase and step
	// ------------------------------------------------------------------
	always_comb begin
		phaseNext = phase;
		stepNext  = 3'd0;
		case (phase)
			controlPkg::phaseClear:  phaseNext = controlPkg::phaseFetch0;
			controlPkg::phaseFetch0: phaseNext = controlPkg::phaseFetch1;
			controlPkg::phaseFetch1: phaseNext = controlPkg::phaseFetch2;
			controlPkg::phaseFetch2: begin
				// Decoded opcode is valid from fetch2 on
				if (opcode == isaPkg::opHalt) begin
					phaseNext = controlPkg::phaseHalted;
				end else begin
					phaseNext = controlPkg::phaseExecute;
				end
			end
			controlPkg::phaseExecute: begin
				if (lastStep) begin
					phaseNext = controlPkg::phaseFetch0;
				end else begin
					stepNext = step + 3'd1;
				end
			end
			// Only reset leaves halt
			controlPkg::phaseHalted: phaseNext = controlPkg::phaseHalted;
			default: phaseNext = controlPkg::phaseClear;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= controlPkg::phaseClear;
			step  <= 3'd0;
		end else begin
			phase <= phaseNext;
			step  <= stepNext;
		end
	end

	assign clear = (phase == controlPkg::phaseClear);
	assign run   = (phase != controlPkg::phaseHalted);

	// IR must stay stable for the whole execute sequence
	assert property (@(posedge clock) disable iff (reset)
		phase == controlPkg::phaseExecute |-> step < execSteps)
		else $error("step %0d out of range for %0d execute steps", step, execSteps);

endmodule

/* tb.f */
+incdir+tb
src/isaPkg.sv
src/controlPkg.sv
src/instructionDecoder.sv
src/stepSequencer.sv
src/controlSignalGenerator.sv
src/controlUnit.sv
tb/tbControlUnit.sv

/* tb/tbVectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Testbench view of the sequencer phases
localparam int phClear   = 0;
localparam int phFetch0  = 1;
localparam int phFetch1  = 2;
localparam int phFetch2  = 3;
localparam int phExecute = 4;
localparam int phHalted  = 5;

localparam int numRows = 28;

// Strobe positions in the compared vector
localparam int bPcOut     = 21;
localparam int bMdrOut    = 20;
localparam int bZOut      = 19;
localparam int bRIn       = 18;
localparam int bROut      = 17;
localparam int bGra       = 16;
localparam int bGrb       = 15;
localparam int bGrc       = 14;
localparam int bBaOut     = 13;
localparam int bCSignOut  = 12;
localparam int bOutPortIn = 11;
localparam int bInPortOut = 10;
localparam int bMdrIn     = 9;
localparam int bMarIn     = 8;
localparam int bYIn       = 7;
localparam int bIrIn      = 6;
localparam int bPcIn      = 5;
localparam int bConIn     = 4;
localparam int bIncPc     = 3;
localparam int bMemRead   = 2;
localparam int bMemWrite  = 1;
localparam int bZIn       = 0;

// ----------------------------------------------------------------------
// Rows are {opcode, conff, execSteps, expectHalt}
// ----------------------------------------------------------------------
function automatic logic [9:0] vectorRow(input int idx);
	case (idx)
		0:       vectorRow = {5'b00000, 1'b0, 3'd5, 1'b0}; // ld
		1:       vectorRow = {5'b00001, 1'b0, 3'd3, 1'b0}; // ldi
		2:       vectorRow = {5'b00010, 1'b0, 3'd4, 1'b0}; // st
		3:       vectorRow = {5'b00011, 1'b0, 3'd3, 1'b0}; // add
		4:       vectorRow = {5'b00100, 1'b1, 3'd3, 1'b0}; // sub
		5:       vectorRow = {5'b00101, 1'b0, 3'd3, 1'b0}; // shr
		6:       vectorRow = {5'b00110, 1'b0, 3'd3, 1'b0}; // shra
		7:       vectorRow = {5'b00111, 1'b1, 3'd3, 1'b0}; // shl
		8:       vectorRow = {5'b01000, 1'b0, 3'd3, 1'b0}; // ror
		9:       vectorRow = {5'b01001, 1'b0, 3'd3, 1'b0}; // rol
		10:      vectorRow = {5'b01010, 1'b0, 3'd3, 1'b0}; // and
		11:      vectorRow = {5'b01011, 1'b0, 3'd3, 1'b0}; // or
		12:      vectorRow = {5'b01100, 1'b0, 3'd3, 1'b0}; // addi
		13:      vectorRow = {5'b01101, 1'b0, 3'd3, 1'b0}; // andi
		14:      vectorRow = {5'b11011, 1'b0, 3'd0, 1'b1}; // halt, then reset
		15:      vectorRow = {5'b01110, 1'b0, 3'd3, 1'b0}; // ori
		16:      vectorRow = {5'b10001, 1'b0, 3'd2, 1'b0}; // neg
		17:      vectorRow = {5'b10010, 1'b0, 3'd2, 1'b0}; // not
		18:      vectorRow = {5'b10011, 1'b0, 3'd4, 1'b0}; // br not taken
		19:      vectorRow = {5'b10011, 1'b1, 3'd4, 1'b0}; // br taken
		20:      vectorRow = {5'b10100, 1'b0, 3'd1, 1'b0}; // jr
		21:      vectorRow = {5'b10110, 1'b0, 3'd2, 1'b0}; // in
		22:      vectorRow = {5'b10111, 1'b0, 3'd1, 1'b0}; // out
		23:      vectorRow = {5'b11010, 1'b0, 3'd1, 1'b0}; // nop
		24:      vectorRow = {5'b11111, 1'b1, 3'd1, 1'b0}; // undefined codes
		25:      vectorRow = {5'b01111, 1'b0, 3'd1, 1'b0};
		26:      vectorRow = {5'b10000, 1'b0, 3'd1, 1'b0};
		default: vectorRow = {5'b10101, 1'b0, 3'd1, 1'b0};
	endcase
endfunction

// ALU function named by an opcode
function automatic logic [3:0] aluForCode(input logic [4:0] code);
	case (code)
		5'b00011, 5'b01100: aluForCode = isaPkg::aluAdd;
		5'b00100:           aluForCode = isaPkg::aluSub;
		5'b01010, 5'b01101: aluForCode = isaPkg::aluAnd;
		5'b01011, 5'b01110: aluForCode = isaPkg::aluOr;
		5'b00101:           aluForCode = isaPkg::aluShr;
		5'b00110:           aluForCode = isaPkg::aluShra;
		5'b00111:           aluForCode = isaPkg::aluShl;
		5'b01000:           aluForCode = isaPkg::aluRor;
		5'b01001:           aluForCode = isaPkg::aluRol;
		5'b10001:           aluForCode = isaPkg::aluNeg;
		5'b10010:           aluForCode = isaPkg::aluNot;
		default:            aluForCode = isaPkg::aluNone;
	endcase
endfunction

function automatic string phaseName(input int phaseSel);
	case (phaseSel)
		phClear:   phaseName = "clear";
		phFetch0:  phaseName = "fetch0";
		phFetch1:  phaseName = "fetch1";
		phFetch2:  phaseName = "fetch2";
		phExecute: phaseName = "execute";
		default:   phaseName = "halted";
	endcase
endfunction

// ----------------------------------------------------------------------
// Expected {run, clear, aluOp, strobes} for one cycle
// ----------------------------------------------------------------------
function automatic logic [27:0] expectedOutputs(input int phaseSel, input int stepIdx,
	input logic [4:0] code, input logic conffIn);
	logic [21:0] s;
	logic [3:0]  alu;
	logic        runExp;
	logic        clearExp;
	s        = '0;
	alu      = isaPkg::aluNone;
	runExp   = 1'b1;
	clearExp = 1'b0;
	case (phaseSel)
		phClear: clearExp = 1'b1;
		phFetch0: begin
			s[bPcOut] = 1'b1;
			s[bMarIn] = 1'b1;
			s[bIncPc] = 1'b1;
			s[bZIn]   = 1'b1;
		end
		phFetch1: begin
			s[bZOut]    = 1'b1;
			s[bPcIn]    = 1'b1;
			s[bMemRead] = 1'b1;
			s[bMdrIn]   = 1'b1;
		end
		phFetch2: begin
			s[bMdrOut] = 1'b1;
			s[bIrIn]   = 1'b1;
		end
		phHalted: runExp = 1'b0;
		default: begin
			case (code)
				// ld, ldi, st share the address calculation
				5'b00000, 5'b00001, 5'b00010: begin
					case (stepIdx)
						0: begin
							s[bGrb]   = 1'b1;
							s[bBaOut] = 1'b1;
							s[bYIn]   = 1'b1;
						end
						1: begin
							s[bCSignOut] = 1'b1;
							alu          = isaPkg::aluAdd;
							s[bZIn]      = 1'b1;
						end
						2: begin
							s[bZOut] = 1'b1;
							if (code == 5'b00001) begin
								s[bGra] = 1'b1;
								s[bRIn] = 1'b1;
							end else begin
								s[bMarIn] = 1'b1;
							end
						end
						3: begin
							if (code == 5'b00000) begin
								s[bMemRead] = 1'b1;
								s[bMdrIn]   = 1'b1;
							end else if (code == 5'b00010) begin
								s[bGra]      = 1'b1;
								s[bROut]     = 1'b1;
								s[bMemWrite] = 1'b1;
							end
						end
						4: begin
							s[bMdrOut] = 1'b1;
							s[bGra]    = 1'b1;
							s[bRIn]    = 1'b1;
						end
						default: ;
					endcase
				end
				5'b00011, 5'b00100, 5'b00101, 5'b00110, 5'b00111, 5'b01000,
				5'b01001, 5'b01010, 5'b01011, 5'b01100, 5'b01101, 5'b01110: begin
					case (stepIdx)
						0: begin
							s[bGrb]  = 1'b1;
							s[bROut] = 1'b1;
							s[bYIn]  = 1'b1;
						end
						1: begin
							// Immediate codes take the constant instead of rC
							if (code >= 5'b01100) begin
								s[bCSignOut] = 1'b1;
							end else begin
								s[bGrc]  = 1'b1;
								s[bROut] = 1'b1;
							end
							alu     = aluForCode(code);
							s[bZIn] = 1'b1;
						end
						2: begin
							s[bZOut] = 1'b1;
							s[bGra]  = 1'b1;
							s[bRIn]  = 1'b1;
						end
						default: ;
					endcase
				end
				5'b10001, 5'b10010: begin
					if (stepIdx == 0) begin
						s[bGrb]  = 1'b1;
						s[bROut] = 1'b1;
						alu      = aluForCode(code);
						s[bZIn]  = 1'b1;
					end else begin
						s[bZOut] = 1'b1;
						s[bGra]  = 1'b1;
						s[bRIn]  = 1'b1;
					end
				end
				5'b10011: begin
					case (stepIdx)
						0: begin
							s[bGra]   = 1'b1;
							s[bROut]  = 1'b1;
							s[bConIn] = 1'b1;
						end
						1: begin
							s[bPcOut] = 1'b1;
							s[bYIn]   = 1'b1;
						end
						2: begin
							s[bCSignOut] = 1'b1;
							alu          = isaPkg::aluAdd;
							s[bZIn]      = 1'b1;
						end
						default: begin
							s[bZOut] = 1'b1;
							s[bPcIn] = conffIn;
						end
					endcase
				end
				5'b10100: begin
					s[bGra]  = 1'b1;
					s[bROut] = 1'b1;
					s[bPcIn] = 1'b1;
				end
				5'b10110: begin
					if (stepIdx == 1) begin
						s[bInPortOut] = 1'b1;
						s[bGra]       = 1'b1;
						s[bRIn]       = 1'b1;
					end
				end
				5'b10111: begin
					s[bGra]       = 1'b1;
					s[bROut]      = 1'b1;
					s[bOutPortIn] = 1'b1;
				end
				// nop and every undefined code
				default: ;
			endcase
		end
	endcase
	return {runExp, clearExp, alu, s};
endfunction

`endif

/* tb/tbControlUnit.sv */
module tbControlUnit;

	localparam int          wordWidth   = 32;
	localparam int          clockPeriod = 8;
	localparam int          resetCycles = 10;
	localparam int          haltCycles  = 10;
	localparam logic [31:0] lcgSeed     = 32'd46499;

	logic                 clock;
	logic                 reset;
	logic [wordWidth-1:0] irReg;
	logic                 conff;
	logic                 pcOut;
	logic                 mdrOut;
	logic                 zOut;
	logic                 rIn;
	logic                 rOut;
	logic                 gra;
	logic                 grb;
	logic                 grc;
	logic                 baOut;
	logic                 cSignOut;
	logic                 outPortIn;
	logic                 inPortOut;
	logic                 mdrIn;
	logic                 marIn;
	logic                 yIn;
	logic                 irIn;
	logic                 pcIn;
	logic                 conIn;
	logic                 incPc;
	logic                 memRead;
	logic                 memWrite;
	logic                 zIn;
	isaPkg::aluOpT        aluOp;
	logic                 run;
	logic                 clear;

	logic [31:0] lcgState;
	int          errorCount;
	int          checkCount;

	`include "tbVectors.svh"

	localparam int timeoutCycles = numRows * 8 + 40;

	controlUnit #(
		.wordWidth(wordWidth)
	) i_controlUnit (
		.clock    (clock),
		.reset    (reset),
		.irReg    (irReg),
		.conff    (conff),
		.pcOut    (pcOut),
		.mdrOut   (mdrOut),
		.zOut     (zOut),
		.rIn      (rIn),
		.rOut     (rOut),
		.gra      (gra),
		.grb      (grb),
		.grc      (grc),
		.baOut    (baOut),
		.cSignOut (cSignOut),
		.outPortIn(outPortIn),
		.inPortOut(inPortOut),
		.mdrIn    (mdrIn),
		.marIn    (marIn),
		.yIn      (yIn),
		.irIn     (irIn),
		.pcIn     (pcIn),
		.conIn    (conIn),
		.incPc    (incPc),
		.memRead  (memRead),
		.memWrite (memWrite),
		.zIn      (zIn),
		.aluOp    (aluOp),
		.run      (run),
		.clear    (clear)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// ------------------------------------------------------------------
	// Compare all outputs at the falling edge
	// ------------------------------------------------------------------
	task automatic checkCycle(input int phaseSel, input int stepIdx, input logic [4:0] code,
		input int rowIdx);
		logic [27:0] expected;
		logic [27:0] actual;
		@(negedge clock);
		expected = expectedOutputs(phaseSel, stepIdx, code, conff);
		actual   = {run, clear, aluOp, pcOut, mdrOut, zOut, rIn, rOut, gra, grb, grc, baOut,
			cSignOut, outPortIn, inPortOut, mdrIn, marIn, yIn, irIn, pcIn, conIn, incPc,
			memRead, memWrite, zIn};
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch at time %0t: row %0d %s step %0d expected %h, got %h",
				$time, rowIdx, phaseName(phaseSel), stepIdx, expected, actual);
		end
	endtask

	// Hold reset and check the clear phase
	task automatic applyReset(input int rowIdx);
		@(posedge clock);
		#1;
		reset = 1'b1;
		for (int i = 0; i < resetCycles; i++) begin
			@(posedge clock);
			#1;
			if (i == resetCycles - 1) begin
				reset = 1'b0;
			end
			checkCycle(phClear, 0, 5'b00000, rowIdx);
		end
	endtask

	task automatic runRow(input int rowIdx);
		logic [9:0]  row;
		logic [4:0]  code;
		logic        expectHalt;
		int          steps;
		logic [31:0] rnd;
		row        = vectorRow(rowIdx);
		code       = row[9:5];
		steps      = row[3:1];
		expectHalt = row[0];

		// IR holds junk until fetch2
		@(posedge clock);
		#1;
		irReg = nextRandom();
		conff = row[4];
		checkCycle(phFetch0, 0, code, rowIdx);
		@(posedge clock);
		#1;
		checkCycle(phFetch1, 0, code, rowIdx);
		@(posedge clock);
		#1;
		rnd   = nextRandom();
		irReg = {code, rnd[wordWidth-6:0]};
		checkCycle(phFetch2, 0, code, rowIdx);

		if (expectHalt) begin
			for (int i = 0; i < haltCycles; i++) begin
				@(posedge clock);
				#1;
				checkCycle(phHalted, 0, code, rowIdx);
			end
			applyReset(rowIdx);
		end else begin
			for (int i = 0; i < steps; i++) begin
				@(posedge clock);
				#1;
				checkCycle(phExecute, i, code, rowIdx);
			end
		end
	endtask

	initial begin
		#(timeoutCycles * clockPeriod);
		$display("Timeout: run did not complete within %0d clock periods", timeoutCycles);
		$display("Simulation FAILED");
		$finish;
	end

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		reset      = 1'b1;
		irReg      = '0;
		conff      = 1'b0;
		lcgState   = lcgSeed;
		errorCount = 0;
		checkCount = 0;

		applyReset(0);
		for (int r = 0; r < numRows; r++) begin
			runRow(r);
		end

		// Last instruction must land back in fetch0
		@(posedge clock);
		#1;
		checkCycle(phFetch0, 0, 5'b11010, numRows);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
